/* verilog.f */
hdl/sram_pkg.sv
hdl/video_pkg.sv
hdl/boot_rom.sv
hdl/sram_arbiter.sv
hdl/scan_fetch.sv
hdl/pixel_fifo.sv
hdl/sram_video_top.sv
bench/sram_checker.sv
bench/tb_sram_video.sv

/* Bender.yml */
package:
  name: sram_video

sources:
  - files:
      - hdl/sram_pkg.sv
      - hdl/video_pkg.sv
      - hdl/boot_rom.sv
      - hdl/sram_arbiter.sv
      - hdl/scan_fetch.sv
      - hdl/pixel_fifo.sv
      - hdl/sram_video_top.sv
  - target: test
    files:
      - bench/sram_checker.sv
      - bench/tb_sram_video.sv

/* bench/tb_sram_video.sv */
`timescale 1ns/1ps

module tb_sram_video;
	import sram_pkg::*;
	import video_pkg::*;

	localparam int unsigned       test_frame = 64;
	localparam logic [addr_w-1:0] test_base  = 'h40000;	// Scratch window off the frame
	localparam int                n_iter     = 8;
	localparam int                n_pix      = 6 * test_frame;
	localparam int                n_ops      = 2 + 2 * boot_words + 12 * n_iter;
	localparam int limit_cycles = 20 * n_ops + 10 + boot_wait + 2 * boot_words + 8 * n_pix + 500;

	logic              clk_50mhz = 1'b0;
	logic              rst, r_stb, r_we, v_stb, v_we, pix_ready;
	logic [addr_w-1:0] r_adr, v_adr, sram_addr;
	logic [ram_w-1:0]  r_dat_w;
	logic [pix_w-1:0]  v_dat_w, pix_data;
	logic [word_w-1:0] r_dat_r, v_dat_r;
	logic              r_ack, v_ack, sram_ce_n, sram_oe_n, sram_we_n, pix_valid, init_done;
	wire  [word_w-1:0] sram_dq;
	logic [word_w-1:0] sram_mem [2**addr_w];
	logic [31:0]       lfsr       = 32'd76108;
	logic [31:0]       ready_lfsr = 32'd76108;	// Own stream for pix_ready
	int                bus_errors, pix_errors, ctl_errors, pix_count;

	always #10 clk_50mhz = ~clk_50mhz;

	sram_video_top #(.FRAME_WORDS(test_frame)) dut0 (.*);
	sram_checker #(.FRAME_WORDS(test_frame)) chk0 (.*);

	////////////////////////////////////////
	// Asynchronous SRAM model
	////////////////////////////////////////

	assign sram_dq = !sram_oe_n ? sram_mem[sram_addr] : {word_w{1'bz}};

	always @(posedge clk_50mhz) begin
		if (!sram_we_n)
			sram_mem[sram_addr] <= sram_dq;	// Taken as we_n rises at slot end
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [word_w-1:0] random_bits(input int n);
		logic [word_w-1:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[word_w-2:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic fill_memory();
		logic [word_w-1:0] w;
		for (int a = 0; a < test_frame; a++) begin
			w = random_bits(word_w);
			sram_mem[frame_base + a] = w;
			chk0.shadow[frame_base + a] = w;
			w = random_bits(word_w);
			sram_mem[test_base + a] = w;
			chk0.shadow[test_base + a] = w;
		end
	endtask

	task automatic cpu_cycle(input logic we, input logic [addr_w-1:0] adr,
		input logic [ram_w-1:0] dat);
		@(posedge clk_50mhz);
		r_stb   <= 1'b1;
		r_we    <= we;
		r_adr   <= adr;
		r_dat_w <= dat;
		do @(posedge clk_50mhz); while (!r_ack);
		r_stb <= 1'b0;
	endtask

	task automatic video_cycle(input logic we, input logic [addr_w-1:0] adr,
		input logic [pix_w-1:0] dat);
		@(posedge clk_50mhz);
		v_stb   <= 1'b1;
		v_we    <= we;
		v_adr   <= adr;
		v_dat_w <= dat;
		do @(posedge clk_50mhz); while (!v_ack);
		v_stb <= 1'b0;
	endtask

	always @(posedge clk_50mhz) begin
		if (rst) begin
			pix_ready <= 1'b0;
		end else begin
			ready_lfsr = lfsr_next(ready_lfsr);
			pix_ready  <= ready_lfsr[0];	// Random display back-pressure
		end
	end

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		logic [addr_w-1:0] adr, adr2;
		logic [ram_w-1:0]  dat;
		logic [pix_w-1:0]  pix;
		rst       = 1'b1;
		r_stb     = 1'b0;
		r_we      = 1'b0;
		r_adr     = '0;
		r_dat_w   = '0;
		v_stb     = 1'b0;
		v_we      = 1'b0;
		v_adr     = '0;
		v_dat_w   = '0;
		pix_ready = 1'b0;
		fill_memory();
		repeat (10) @(posedge clk_50mhz);
		rst   <= 1'b0;
		r_stb <= 1'b1;	// Held high through the boot with no ack expected
		r_adr <= addr_w'(boot_base);
		v_stb <= 1'b1;
		v_adr <= addr_w'(boot_base + 1);
		do @(posedge clk_50mhz); while (!r_ack);
		r_stb <= 1'b0;
		do @(posedge clk_50mhz); while (!v_ack);
		v_stb <= 1'b0;

		for (int i = 0; i < boot_words; i++) begin
			cpu_cycle(1'b0, addr_w'(boot_base + i), '0);
			video_cycle(1'b0, addr_w'(boot_base + i), '0);
		end

		for (int i = 0; i < n_iter; i++) begin
			adr = test_base + addr_w'(random_bits(6));
			video_cycle(1'b0, adr, '0);
			cpu_cycle(1'b1, adr, ram_w'(random_bits(ram_w)));
			video_cycle(1'b0, adr, '0);
			cpu_cycle(1'b0, adr, '0);
		end

		for (int i = 0; i < n_iter; i++) begin
			adr = test_base + addr_w'(random_bits(6));
			cpu_cycle(1'b0, adr, '0);
			video_cycle(1'b1, adr, pix_w'(random_bits(pix_w)));
			cpu_cycle(1'b0, adr, '0);
			video_cycle(1'b0, adr, '0);
		end

		// Contention on the same word in odd rounds
		for (int i = 0; i < n_iter; i++) begin
			adr  = test_base + addr_w'(random_bits(6));
			adr2 = i[0] ? adr : test_base + addr_w'(random_bits(6));
			dat  = ram_w'(random_bits(ram_w));
			pix  = pix_w'(random_bits(pix_w));
			fork
				begin
					cpu_cycle(1'b1, adr, dat);
					cpu_cycle(1'b0, adr, '0);
				end
				begin
					video_cycle(1'b1, adr2, pix);
					video_cycle(1'b0, adr2, '0);
				end
			join
		end

		while (pix_count < n_pix)
			@(posedge clk_50mhz);
		repeat (4) @(posedge clk_50mhz);
		$display("errors: bus %0d, pixel %0d, control %0d", bus_errors, pix_errors, ctl_errors);
		if (bus_errors + pix_errors + ctl_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		repeat (limit_cycles) @(posedge clk_50mhz);
		$display("Run timed out after %0d cycles waiting for ack or pixels", limit_cycles);
		$display("errors: bus %0d, pixel %0d, control %0d", bus_errors, pix_errors, ctl_errors);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* bench/sram_checker.sv */
`timescale 1ns/1ps

module sram_checker #(
	parameter int unsigned BOOT_BASE   = video_pkg::boot_base,
	parameter int unsigned BOOT_WORDS  = video_pkg::boot_words,
	parameter int unsigned FRAME_BASE  = video_pkg::frame_base,
	parameter int unsigned FRAME_WORDS = video_pkg::frame_words
) (
	input  logic                        clk_50mhz, rst,
	input  logic                        r_stb, r_we, r_ack,
	input  logic [sram_pkg::addr_w-1:0] r_adr,
	input  logic [sram_pkg::ram_w-1:0]  r_dat_w,
	input  logic [sram_pkg::word_w-1:0] r_dat_r,
	input  logic                        v_stb, v_we, v_ack,
	input  logic [sram_pkg::addr_w-1:0] v_adr,
	input  logic [sram_pkg::pix_w-1:0]  v_dat_w,
	input  logic [sram_pkg::word_w-1:0] v_dat_r,
	input  logic [sram_pkg::addr_w-1:0] sram_addr,
	input  logic                        sram_ce_n, sram_oe_n, sram_we_n,
	input  wire  [sram_pkg::word_w-1:0] sram_dq,
	input  logic [sram_pkg::pix_w-1:0]  pix_data,
	input  logic                        pix_valid, pix_ready, init_done,
	output int                          bus_errors, pix_errors, ctl_errors, pix_count
);
	import sram_pkg::*;
	import video_pkg::*;

	logic [word_w-1:0] shadow [2**addr_w];	// Expected SRAM contents
	logic              r_stb_q, v_stb_q, init_q;
	logic              r_owed;	// Set while r still waits after a shared start
	int                boot_cyc, pix_idx;
	int                err_bus = 0;
	int                err_pix = 0;
	int                err_ctl = 0;
	int                seen = 0;

	assign bus_errors = err_bus;
	assign pix_errors = err_pix;
	assign ctl_errors = err_ctl;
	assign pix_count  = seen;

	// Boot image of pixel i * 0101h over data i ^ C0DE0000h
	task automatic load_boot_image();
		for (int i = 0; i < BOOT_WORDS; i++)
			shadow[BOOT_BASE + i] = {pix_w'(i * 'h0101), ram_w'(i) ^ ram_w'('hC0DE0000)};
	endtask

	task automatic compare_read(input string port, input logic [word_w-1:0] want, got);
		if (got !== want) begin
			$display("[FAIL] %0d ns: %s read expected %h, got %h", $time, port, want, got);
			err_bus++;
		end
	endtask

	always @(posedge clk_50mhz) begin
		if (rst) begin
			boot_cyc <= 0;
			pix_idx  <= 0;
			r_owed   <= 1'b0;
			r_stb_q  <= 1'b0;
			v_stb_q  <= 1'b0;
			init_q   <= 1'b0;
		end else begin
			boot_cyc <= boot_cyc + 1;
			r_stb_q  <= r_stb;
			v_stb_q  <= v_stb;
			init_q   <= init_done;
			if (sram_ce_n !== 1'b0) begin
				$display("%0d ns: SRAM chip enable not held low", $time);
				err_ctl++;
			end
			if (boot_cyc < boot_wait && !sram_we_n) begin
				$display("%0d ns: SRAM written during the boot wait", $time);
				err_ctl++;
			end
			if (init_done && !init_q)
				load_boot_image();
			if ((r_ack || v_ack) && !init_done) begin
				$display("%0d ns: bus ack seen before init_done", $time);
				err_ctl++;
			end

			// Both ports starting together means r goes first
			if (r_stb && v_stb && !r_stb_q && !v_stb_q)
				r_owed <= 1'b1;
			else if (r_ack)
				r_owed <= 1'b0;
			if (v_ack && r_owed) begin
				$display("%0d ns: v port acked while r was still waiting", $time);
				err_ctl++;
			end

			if (r_ack) begin
				if (r_we)
					shadow[r_adr][ram_w-1:0] = r_dat_w;	// Pixel field kept
				else
					compare_read("r port", {{pix_w{1'b0}}, shadow[r_adr][ram_w-1:0]}, r_dat_r);
			end
			if (v_ack) begin
				if (v_we)
					shadow[v_adr][word_w-1:ram_w] = v_dat_w;	// Data field kept
				else
					compare_read("v port", {{ram_w{1'b0}}, shadow[v_adr][word_w-1:ram_w]}, v_dat_r);
			end

			// Display stream walks the frame in order
			if (pix_valid && pix_ready) begin
				if (pix_data !== shadow[FRAME_BASE + pix_idx][word_w-1:ram_w]) begin
					$display("[FAIL] %0d ns: pixel %0d expected %h, got %h", $time, seen,
						shadow[FRAME_BASE + pix_idx][word_w-1:ram_w], pix_data);
					err_pix++;
				end
				seen++;
				pix_idx <= (pix_idx == FRAME_WORDS - 1) ? 0 : pix_idx + 1;
			end
		end
	end

endmodule

/* hdl/sram_video_top.sv */
`timescale 1ns/1ps

module sram_video_top #(
	parameter int unsigned BOOT_BASE   = video_pkg::boot_base,
	parameter int unsigned BOOT_WORDS  = video_pkg::boot_words,
	parameter int unsigned FRAME_BASE  = video_pkg::frame_base,
	parameter int unsigned FRAME_WORDS = video_pkg::frame_words,
	parameter int unsigned FIFO_DEPTH  = 8
) (
	input  logic                        clk_50mhz,
	input  logic                        rst,
	input  logic                        r_stb,
	input  logic                        r_we,
	input  logic [sram_pkg::addr_w-1:0] r_adr,
	input  logic [sram_pkg::ram_w-1:0]  r_dat_w,
	output logic [sram_pkg::word_w-1:0] r_dat_r,
	output logic                        r_ack,
	input  logic                        v_stb,
	input  logic                        v_we,
	input  logic [sram_pkg::addr_w-1:0] v_adr,
	input  logic [sram_pkg::pix_w-1:0]  v_dat_w,
	output logic [sram_pkg::word_w-1:0] v_dat_r,
	output logic                        v_ack,
	output logic [sram_pkg::addr_w-1:0] sram_addr,
	output logic                        sram_ce_n,
	output logic                        sram_oe_n,
	output logic                        sram_we_n,
	inout  wire  [sram_pkg::word_w-1:0] sram_dq,
	output logic [sram_pkg::pix_w-1:0]  pix_data,
	output logic                        pix_valid,
	input  logic                        pix_ready,
	output logic                        init_done
);
	import sram_pkg::*;

	// Boot image path
	logic [$clog2(BOOT_WORDS)-1:0] rom_addr;
	logic [word_w-1:0]             rom_data;

	// Scan path
	logic                            scan_req, scan_take, scan_valid;
	logic [addr_w-1:0]               scan_addr;
	logic [pix_w-1:0]                scan_pix;
	logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_level;

	sram_arbiter #(.BOOT_BASE(BOOT_BASE), .BOOT_WORDS(BOOT_WORDS)) arb0 (
		.clk_50mhz, .rst,
		.r_stb, .r_we, .r_adr, .r_dat_w, .r_dat_r, .r_ack,
		.v_stb, .v_we, .v_adr, .v_dat_w, .v_dat_r, .v_ack,
		.scan_req, .scan_addr, .scan_take, .scan_valid, .scan_pix,
		.rom_addr, .rom_data, .init_done,
		.sram_addr, .sram_ce_n, .sram_oe_n, .sram_we_n, .sram_dq
	);

	boot_rom #(.BOOT_WORDS(BOOT_WORDS)) rom0 (
		.clk_50mhz, .addr(rom_addr), .data(rom_data)
	);

	scan_fetch #(
		.FRAME_BASE(FRAME_BASE), .FRAME_WORDS(FRAME_WORDS), .FIFO_DEPTH(FIFO_DEPTH)
	) fetch0 (
		.clk_50mhz, .rst, .fifo_level, .scan_take, .scan_valid, .scan_req, .scan_addr
	);

	pixel_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo0 (
		.clk_50mhz, .rst,
		.push(scan_valid), .push_data(scan_pix),
		.pop_ready(pix_ready), .pop_data(pix_data), .pop_valid(pix_valid),
		.level(fifo_level)
	);

endmodule

/* hdl/pixel_fifo.sv */
`timescale 1ns/1ps

module pixel_fifo #(
	parameter int unsigned FIFO_DEPTH = 8
) (
	input  logic                            clk_50mhz,
	input  logic                            rst,
	input  logic                            push,
	input  logic [sram_pkg::pix_w-1:0]      push_data,
	input  logic                            pop_ready,
	output logic [sram_pkg::pix_w-1:0]      pop_data,
	output logic                            pop_valid,
	output logic [$clog2(FIFO_DEPTH+1)-1:0] level
);
	import sram_pkg::*;

	localparam int ptr_w = $clog2(FIFO_DEPTH);

	logic [pix_w-1:0] mem [FIFO_DEPTH];
	logic [ptr_w-1:0] wr_ptr, rd_ptr;
	logic             do_push, do_pop;

	assign pop_valid = (level != 0);
	assign pop_data  = mem[rd_ptr];	// Show-ahead output
	assign do_pop    = pop_valid && pop_ready;
	assign do_push   = push && ((level != FIFO_DEPTH) || do_pop);

	always_ff @(posedge clk_50mhz) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk_50mhz) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;	// Both or neither
			endcase
		end
	end

endmodule

/* hdl/scan_fetch.sv */
`timescale 1ns/1ps

module scan_fetch #(
	parameter int unsigned FRAME_BASE  = video_pkg::frame_base,
	parameter int unsigned FRAME_WORDS = video_pkg::frame_words,
	parameter int unsigned FIFO_DEPTH  = 8
) (
	input  logic                           clk_50mhz,
	input  logic                           rst,
	input  logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_level,
	input  logic                           scan_take,
	input  logic                           scan_valid,
	output logic                           scan_req,
	output logic [sram_pkg::addr_w-1:0]    scan_addr
);
	import sram_pkg::*;

	localparam int cnt_w = $clog2(FIFO_DEPTH + 1);
	localparam int off_w = $clog2(FRAME_WORDS);

	logic [off_w-1:0] offset;	// Position inside the frame
	logic [cnt_w-1:0] in_flight;	// Taken but not yet valid
	logic [cnt_w:0]   committed;

	// Words already promised to the FIFO, this cycle's take included
	assign committed = fifo_level + in_flight + scan_take;
	assign scan_addr = addr_w'(FRAME_BASE) + addr_w'(offset);

	always_ff @(posedge clk_50mhz) begin
		if (rst) begin
			offset    <= '0;
			in_flight <= '0;
			scan_req  <= 1'b0;
		end else begin
			if (scan_take)
				offset <= (offset == off_w'(FRAME_WORDS - 1)) ? '0 : offset + 1'b1;
			case ({scan_take, scan_valid})
				2'b10:   in_flight <= in_flight + 1'b1;
				2'b01:   in_flight <= in_flight - 1'b1;
				default: in_flight <= in_flight;
			endcase
			scan_req <= committed < FIFO_DEPTH;	// Never overfill the FIFO
		end
	end

endmodule

/* hdl/sram_arbiter.sv */
`timescale 1ns/1ps

module sram_arbiter #(
	parameter int unsigned BOOT_BASE  = video_pkg::boot_base,
	parameter int unsigned BOOT_WORDS = video_pkg::boot_words
) (
	input  logic                          clk_50mhz,
	input  logic                          rst,
	input  logic                          r_stb,
	input  logic                          r_we,
	input  logic [sram_pkg::addr_w-1:0]   r_adr,
	input  logic [sram_pkg::ram_w-1:0]    r_dat_w,
	output logic [sram_pkg::word_w-1:0]   r_dat_r,
	output logic                          r_ack,
	input  logic                          v_stb,
	input  logic                          v_we,
	input  logic [sram_pkg::addr_w-1:0]   v_adr,
	input  logic [sram_pkg::pix_w-1:0]    v_dat_w,
	output logic [sram_pkg::word_w-1:0]   v_dat_r,
	output logic                          v_ack,
	input  logic                          scan_req,
	input  logic [sram_pkg::addr_w-1:0]   scan_addr,
	output logic                          scan_take,
	output logic                          scan_valid,
	output logic [sram_pkg::pix_w-1:0]    scan_pix,
	output logic [$clog2(BOOT_WORDS)-1:0] rom_addr,
	input  logic [sram_pkg::word_w-1:0]   rom_data,
	output logic                          init_done,
	output logic [sram_pkg::addr_w-1:0]   sram_addr,
	output logic                          sram_ce_n,
	output logic                          sram_oe_n,
	output logic                          sram_we_n,
	inout  wire  [sram_pkg::word_w-1:0]   sram_dq
);
	import sram_pkg::*;
	import video_pkg::*;

	localparam int idx_w  = $clog2(BOOT_WORDS);
	localparam int wait_w = $clog2(boot_wait + 1);

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_rd   = 2'd1;	// Read old word
	localparam logic [1:0] st_wr   = 2'd2;	// Write merged word
	localparam logic [1:0] st_ack  = 2'd3;

	logic              phase;	// 1 = scan slot, 0 = bus slot
	logic [1:0]        state;
	logic              sel_r;	// Port that owns the current access
	logic [wait_w-1:0] wait_cnt;
	logic [idx_w-1:0]  boot_idx;
	logic              copying;
	logic              boot_slot, rd_slot, wr_slot;
	logic              bus_we;
	logic [addr_w-1:0] bus_adr;
	sram_word_t        dq_in, merged, hold;
	logic [word_w-1:0] wr_word;

	////////////////////////////////////////
	// Slot phase and boot copy
	////////////////////////////////////////

	always_ff @(posedge clk_50mhz) begin
		if (rst)
			phase <= 1'b0;
		else
			phase <= ~phase;
	end

	assign copying   = (wait_cnt == wait_w'(boot_wait)) && !init_done;
	assign boot_slot = copying && !phase;
	assign rom_addr  = boot_idx;	// ROM word is ready by the next bus slot

	always_ff @(posedge clk_50mhz) begin
		if (rst) begin
			wait_cnt  <= '0;
			boot_idx  <= '0;
			init_done <= 1'b0;
		end else begin
			if (wait_cnt != wait_w'(boot_wait))
				wait_cnt <= wait_cnt + 1'b1;
			if (boot_slot) begin
				boot_idx <= boot_idx + 1'b1;
				if (boot_idx == idx_w'(BOOT_WORDS - 1))
					init_done <= 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Scan slot
	////////////////////////////////////////

	assign scan_take = phase && scan_req;

	always_ff @(posedge clk_50mhz) begin
		if (rst)
			scan_valid <= 1'b0;
		else
			scan_valid <= scan_take;
	end

	always_ff @(posedge clk_50mhz) begin
		if (scan_take)
			scan_pix <= dq_in.split.pix;
	end

	////////////////////////////////////////
	// Bus FSM with read-modify-write
	////////////////////////////////////////

	assign bus_we  = sel_r ? r_we : v_we;
	assign bus_adr = sel_r ? r_adr : v_adr;
	assign rd_slot = (state == st_rd) && !phase;
	assign wr_slot = (state == st_wr) && !phase;

	always_ff @(posedge clk_50mhz) begin
		if (rst) begin
			state <= st_idle;
			sel_r <= 1'b0;
		end else begin
			case (state)
				st_idle: if (init_done && (r_stb || v_stb)) begin
					sel_r <= r_stb;	// r has priority
					state <= st_rd;
				end
				st_rd: if (!phase) state <= bus_we ? st_wr : st_ack;
				st_wr: if (!phase) state <= st_ack;
				default: state <= st_idle;
			endcase
		end
	end

	// Replace only the owning port's field
	always_comb begin
		merged = dq_in;
		if (sel_r)
			merged.split.data = r_dat_w;
		else
			merged.split.pix = v_dat_w;
	end

	always_ff @(posedge clk_50mhz) begin
		if (rd_slot)
			hold <= bus_we ? merged : dq_in;
	end

	assign r_ack   = (state == st_ack) && sel_r;
	assign v_ack   = (state == st_ack) && !sel_r;
	assign r_dat_r = {{pix_w{1'b0}}, hold.split.data};
	assign v_dat_r = {{ram_w{1'b0}}, hold.split.pix};

	////////////////////////////////////////
	// SRAM pins
	////////////////////////////////////////

	assign dq_in.raw = sram_dq;
	assign wr_word   = copying ? rom_data : hold.raw;
	assign sram_dq   = (boot_slot || wr_slot) ? wr_word : {word_w{1'bz}};
	assign sram_ce_n = 1'b0;
	assign sram_oe_n = !(scan_take || rd_slot);
	assign sram_we_n = !(boot_slot || wr_slot);

	always_comb begin
		if (phase)
			sram_addr = scan_addr;
		else if (copying)
			sram_addr = addr_w'(BOOT_BASE) + addr_w'(boot_idx);
		else
			sram_addr = bus_adr;
	end

endmodule

/* hdl/boot_rom.sv */
`timescale 1ns/1ps

module boot_rom #(
	parameter int unsigned BOOT_WORDS = video_pkg::boot_words
) (
	input  logic                          clk_50mhz,
	input  logic [$clog2(BOOT_WORDS)-1:0] addr,
	output logic [sram_pkg::word_w-1:0]   data
);
	import sram_pkg::*;

	// Image word i: pixel i * 0101h, data i ^ C0DE0000h
	function automatic logic [word_w-1:0] image_word(
		input logic [$clog2(BOOT_WORDS)-1:0] i
	);
		logic [pix_w-1:0] pix;
		logic [ram_w-1:0] dat;
		pix = pix_w'(i) * pix_w'('h0101);
		dat = ram_w'(i) ^ ram_w'('hC0DE0000);
		return {pix, dat};
	endfunction

	// One cycle read latency
	always_ff @(posedge clk_50mhz) begin
		data <= image_word(addr);
	end

endmodule

/* hdl/video_pkg.sv */
package video_pkg;

	////////////////////////////////////////
	// Scan frame
	////////////////////////////////////////

	parameter int unsigned frame_base  = 'h00000;
	parameter int unsigned frame_words = 'h4B000;	// 640 x 480 pixels

	////////////////////////////////////////
	// Boot image
	////////////////////////////////////////

	parameter int unsigned boot_base  = 'h80000;
	parameter int unsigned boot_words = 32;
	parameter int unsigned boot_wait  = 10;	// Idle cycles before the copy

endpackage

/* hdl/sram_pkg.sv */
package sram_pkg;

	////////////////////////////////////////
	// External SRAM geometry
	////////////////////////////////////////

	parameter int addr_w = 20;
	parameter int word_w = 48;	// Full SRAM data bus
	parameter int ram_w  = 32;	// Processor field, low bits
	parameter int pix_w  = 16;	// Pixel field, high bits

	// Field view of one SRAM word
	typedef struct packed {
		logic [pix_w-1:0] pix;
		logic [ram_w-1:0] data;
	} sram_split_t;

	// Same 48 bits seen as the pin word or as two fields
	typedef union packed {
		logic [word_w-1:0] raw;
		sram_split_t       split;
	} sram_word_t;

endpackage
